//--- common/i2c_op_if.sv
//----------------------------------------------------------
// byte operation link between the i2c master control FSM
// and its bus sequencer and shift register
//----------------------------------------------------------
`timescale 1ns/100ps

interface i2c_op_if import i2c_pkg::*; (
    input logic dri_clk
);

    logic  go;                                   // one-cycle start of an operation
    op_e   op;
    byte_t tx_byte;
    logic  op_done;                              // last cycle of the operation
    byte_t rx_byte;
    logic  ack_n;                                // last sampled bit, slave ack on writes

    modport ctrl (
        input  dri_clk,
        output go, op, tx_byte,
        input  op_done, rx_byte, ack_n
    );

    modport seq (
        input  dri_clk,
        input  go, op,
        output op_done
    );

    modport shift (
        input  dri_clk,
        input  tx_byte,
        output rx_byte, ack_n
    );

endinterface

//--- common/i2c_pkg.sv
//----------------------------------------------------------
// i2c master shared types
// byte, address and state encodings for the EEPROM master
//----------------------------------------------------------

package i2c_pkg;

    typedef logic [7:0]  byte_t;                 // data or address byte
    typedef logic [15:0] word_addr_t;            // word address inside the EEPROM
    typedef logic [6:0]  dev_addr_t;             // 7-bit device address

    // byte-level bus operations
    typedef enum logic [2:0] {
        op_start_wr   = 3'd0,                    // start, byte, ack
        op_wr         = 3'd1,                    // byte, ack
        op_restart_wr = 3'd2,                    // repeated start, byte, ack
        op_rd         = 3'd3,                    // byte in, master nack
        op_stop       = 3'd4                     // stop and bus hold
    } op_e;

    // transaction states, one-hot
    typedef enum logic [7:0] {
        st_idle    = 8'b0000_0001,
        st_sladdr  = 8'b0000_0010,               // device address, write bit
        st_addr16  = 8'b0000_0100,               // upper word address byte
        st_addr8   = 8'b0000_1000,               // lower word address byte
        st_data_wr = 8'b0001_0000,
        st_addr_rd = 8'b0010_0000,               // device address, read bit
        st_data_rd = 8'b0100_0000,
        st_stop    = 8'b1000_0000
    } state_e;

    //----------------------------------------------------------
    // bus timing
    //----------------------------------------------------------
    localparam int bit_cycles   = 4;             // dri_clk cycles per scl bit
    localparam int start_cycles = 4;             // extra cycles of a (re)start

endpackage

//--- i2c_ctrl/i2c_ctrl.sv
//----------------------------------------------------------
// i2c master transaction control
// walks one EEPROM write or random read, one byte op per state
//----------------------------------------------------------
`timescale 1ns/100ps

module i2c_ctrl import i2c_pkg::*; (
    input  logic       dri_clk,
    input  logic       rst_n,
    input  logic       exec,
    input  logic       addr16,
    input  logic       rd,
    input  dev_addr_t  dev_addr,
    input  word_addr_t word_addr,
    input  byte_t      data_w,
    output byte_t      data_r,
    output logic       done,
    output logic       nack,
    i2c_op_if.ctrl     op
);

    state_e     state;
    state_e     state_nxt;
    logic       go_q;
    logic       ack_chk;                         // ack_n valid this cycle
    logic       addr16_q;
    logic       rd_q;
    dev_addr_t  dev_q;
    word_addr_t waddr_q;
    byte_t      wdata_q;

    always_comb begin
        case (state)
            st_sladdr:  state_nxt = addr16_q ? st_addr16 : st_addr8;
            st_addr16:  state_nxt = st_addr8;
            st_addr8:   state_nxt = rd_q ? st_addr_rd : st_data_wr;
            st_addr_rd: state_nxt = st_data_rd;
            st_stop:    state_nxt = st_idle;
            default:    state_nxt = st_stop;     // after data write or read
        endcase
    end

    //----------------------------------------------------------
    // state, go strobe, nack flag, done
    //----------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            go_q    <= 1'b0;
            ack_chk <= 1'b0;
            done    <= 1'b0;
            nack    <= 1'b0;
        end else begin
            go_q    <= 1'b0;
            done    <= 1'b0;
            ack_chk <= op.op_done && (state != st_data_rd) && (state != st_stop);
            if (ack_chk)
                nack <= nack | op.ack_n;         // sticky until next exec
            if (state == st_idle) begin
                if (exec) begin
                    state <= st_sladdr;
                    go_q  <= 1'b1;
                    nack  <= 1'b0;
                end
            end else if (op.op_done) begin
                state <= state_nxt;
                go_q  <= (state != st_stop);
                done  <= (state == st_stop);
            end
        end
    end

    // request latch and read result
    always_ff @(posedge dri_clk) begin
        if (state == st_idle && exec) begin
            addr16_q <= addr16;
            rd_q     <= rd;
            dev_q    <= dev_addr;
            waddr_q  <= word_addr;
            wdata_q  <= data_w;
        end
        if (go_q && state == st_stop && rd_q)
            data_r <= op.rx_byte;                // read byte held after op_rd
    end

    assign op.go = go_q;

    always_comb begin
        case (state)
            st_sladdr: begin
                op.op      = op_start_wr;
                op.tx_byte = {dev_q, 1'b0};      // write bit
            end
            st_addr16: begin
                op.op      = op_wr;
                op.tx_byte = waddr_q[15:8];
            end
            st_addr8: begin
                op.op      = op_wr;
                op.tx_byte = waddr_q[7:0];
            end
            st_data_wr: begin
                op.op      = op_wr;
                op.tx_byte = wdata_q;
            end
            st_addr_rd: begin
                op.op      = op_restart_wr;
                op.tx_byte = {dev_q, 1'b1};      // read bit
            end
            st_data_rd: begin
                op.op      = op_rd;
                op.tx_byte = 8'hff;
            end
            default: begin
                op.op      = op_stop;
                op.tx_byte = 8'hff;
            end
        endcase
    end

    // no new operation until the sequencer reports the running one done
    a_go_idle: assert property (@(posedge dri_clk) disable iff (!rst_n)
        op.go |=> (!op.go) until_with op.op_done);

    a_state_legal: assert property (@(posedge dri_clk) disable iff (!rst_n)
        state inside {st_idle, st_sladdr, st_addr16, st_addr8,
                      st_data_wr, st_addr_rd, st_data_rd, st_stop});

endmodule

//--- rtl/i2c_bus_seq.sv
//----------------------------------------------------------
// i2c bus sequencer
// times scl, sda and the shifter strobes within one byte op
//----------------------------------------------------------
`timescale 1ns/100ps

module i2c_bus_seq import i2c_pkg::*; #(
    parameter int stop_hold = 12
) (
    input  logic   dri_clk,
    input  logic   rst_n,
    input  logic   sda_in,
    i2c_op_if.seq  op,
    input  logic   tx_bit,
    output logic   load,
    output logic   shift,
    output logic   sample,
    output logic   scl,
    output logic   sda_drive,
    output logic   sda_en
);

    localparam int frame_bits = 9;               // 8 data bits and ack
    localparam int max_len    = start_cycles + (frame_bits + 1) * bit_cycles + stop_hold;
    localparam int cnt_w      = $clog2(max_len + 1);

    logic             busy;
    logic [cnt_w-1:0] cnt;                       // bus position now shown
    op_e              op_q;
    logic             scl_q;
    logic             lvl_q;                     // sda level outside data bits
    logic             en_q;
    logic             tx_sel_q;                  // sda follows tx_bit
    logic [3:0]       nxt;
    logic             cur_pre;
    logic [cnt_w-1:0] cur_rel;
    logic [3:0]       cur_b;
    logic [1:0]       cur_q;
    logic             data_ph;

    function automatic logic has_pre(op_e o);
        return (o == op_start_wr) || (o == op_restart_wr);
    endfunction

    function automatic logic [cnt_w-1:0] last_pos(op_e o);
        if (o == op_stop)
            return cnt_w'(bit_cycles + stop_hold - 2);
        else if (has_pre(o))
            return cnt_w'(start_cycles + frame_bits * bit_cycles - 2);
        else
            return cnt_w'(frame_bits * bit_cycles - 2);
    endfunction

    // bus levels at position p of an op: {scl, level, enable, tx select}
    function automatic logic [3:0] bus_at(op_e o, logic [cnt_w-1:0] p);
        logic [cnt_w-1:0] rel;
        logic [3:0]       b;
        logic [1:0]       q;
        logic             scl_v;
        logic             lvl_v;
        logic             en_v;
        logic             sel_v;
        rel   = has_pre(o) ? p - cnt_w'(start_cycles) : p;
        b     = 4'(rel / bit_cycles);
        q     = 2'(rel % bit_cycles);
        scl_v = (q == 2'd1) || (q == 2'd2);      // high in the middle quarters
        lvl_v = 1'b1;
        en_v  = 1'b1;
        sel_v = 1'b0;
        if (o == op_stop) begin
            scl_v = (p != '0);
            lvl_v = (p >= cnt_w'(bit_cycles));   // sda rises with scl high
        end else if (has_pre(o) && p < cnt_w'(start_cycles)) begin
            scl_v = (p[1:0] != 2'd3) && ((p[1:0] != 2'd0) || (o == op_start_wr));
            lvl_v = (p[1:0] < 2'd2);             // sda falls with scl high
        end else if (b < 4'd8) begin
            en_v  = (o != op_rd);                // released for read bits
            sel_v = (o != op_rd);
        end else begin
            en_v = (o == op_rd);                 // master nack, else slave ack
        end
        return {scl_v, lvl_v, en_v, sel_v};
    endfunction

    assign nxt = busy ? bus_at(op_q, cnt + 1'b1) : bus_at(op.op, '0);

    //----------------------------------------------------------
    // position counter and registered bus levels
    //----------------------------------------------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            cnt      <= '0;
            op_q     <= op_stop;
            scl_q    <= 1'b1;
            lvl_q    <= 1'b1;
            en_q     <= 1'b0;                    // bus released after reset
            tx_sel_q <= 1'b0;
        end else if (!busy) begin
            if (op.go) begin
                busy                           <= 1'b1;
                cnt                            <= '0;
                op_q                           <= op.op;
                {scl_q, lvl_q, en_q, tx_sel_q} <= nxt;
            end
        end else begin
            cnt                            <= cnt + 1'b1;
            {scl_q, lvl_q, en_q, tx_sel_q} <= nxt;
            if (op.op_done)
                busy <= 1'b0;
        end
    end

    // decode of the position on the bus
    always_comb begin
        cur_pre = has_pre(op_q) && (cnt < cnt_w'(start_cycles));
        cur_rel = has_pre(op_q) ? cnt - cnt_w'(start_cycles) : cnt;
        cur_b   = 4'(cur_rel / bit_cycles);
        cur_q   = 2'(cur_rel % bit_cycles);
        data_ph = busy && (op_q != op_stop) && !cur_pre;
    end

    assign op.op_done = busy && (cnt == last_pos(op_q));
    assign load       = op.go && !busy;
    assign shift      = data_ph && (cur_q == 2'd3) && (cur_b < 4'd7) && (op_q != op_rd);
    assign sample     = data_ph && (cur_q == 2'd2) && ((cur_b < 4'd8) == (op_q == op_rd));

    assign scl       = scl_q;
    assign sda_en    = en_q;
    assign sda_drive = tx_sel_q ? tx_bit : lvl_q;

    // the line itself, master and slave together
    a_sda_stable: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (scl_q && $past(scl_q) && !(busy && (op_q == op_stop || cur_pre)) &&
         !$past(busy && (op_q == op_stop || cur_pre))) |-> $stable(sda_in));

endmodule

//--- rtl/i2c_master_top.sv
//----------------------------------------------------------
// i2c EEPROM master top level
// one byte write or random read per exec, open-drain sda
//----------------------------------------------------------
`timescale 1ns/100ps

module i2c_master_top import i2c_pkg::*; #(
    parameter int stop_hold = 12
) (
    input  logic       dri_clk,
    input  logic       rst_n,
    input  logic       exec,
    input  logic       addr16,
    input  logic       rd,
    input  dev_addr_t  dev_addr,
    input  word_addr_t word_addr,
    input  byte_t      data_w,
    output byte_t      data_r,
    output logic       done,
    output logic       nack,
    output logic       scl,
    inout  wire        sda
);

    logic load;
    logic shift;
    logic sample;
    logic tx_bit;
    logic sda_drive;
    logic sda_en;
    logic sda_in;

    i2c_op_if op_if (.dri_clk(dri_clk));

    // open drain, a high level is left to the pull-up
    assign sda    = (sda_en && !sda_drive) ? 1'b0 : 1'bz;
    assign sda_in = sda;

    i2c_ctrl ctrl_i (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .exec      (exec),
        .addr16    (addr16),
        .rd        (rd),
        .dev_addr  (dev_addr),
        .word_addr (word_addr),
        .data_w    (data_w),
        .data_r    (data_r),
        .done      (done),
        .nack      (nack),
        .op        (op_if.ctrl)
    );

    i2c_bus_seq #(.stop_hold(stop_hold)) seq_i (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .sda_in    (sda_in),
        .op        (op_if.seq),
        .tx_bit    (tx_bit),
        .load      (load),
        .shift     (shift),
        .sample    (sample),
        .scl       (scl),
        .sda_drive (sda_drive),
        .sda_en    (sda_en)
    );

    i2c_shift_reg shift_i (
        .dri_clk (dri_clk),
        .rst_n   (rst_n),
        .load    (load),
        .shift   (shift),
        .sample  (sample),
        .sda_in  (sda_in),
        .tx_bit  (tx_bit),
        .op      (op_if.shift)
    );

endmodule

//--- rtl/i2c_shift_reg.sv
//----------------------------------------------------------
// i2c shifters
// msb-first transmit byte, receive byte and ack capture
//----------------------------------------------------------
`timescale 1ns/100ps

module i2c_shift_reg import i2c_pkg::*; (
    input  logic    dri_clk,
    input  logic    rst_n,
    input  logic    load,
    input  logic    shift,
    input  logic    sample,
    input  logic    sda_in,
    output logic    tx_bit,
    i2c_op_if.shift op
);

    byte_t tx_sr;
    byte_t rx_sr;
    logic  ack_q;

    always_ff @(posedge dri_clk) begin
        if (load)
            tx_sr <= op.tx_byte;
        else if (shift)
            tx_sr <= {tx_sr[6:0], 1'b1};         // next bit to msb
        if (sample)
            rx_sr <= {rx_sr[6:0], sda_in};
    end

    // on writes the only sample is the ack bit
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n)
            ack_q <= 1'b0;
        else if (sample)
            ack_q <= sda_in;
    end

    assign tx_bit     = tx_sr[7];
    assign op.rx_byte = rx_sr;
    assign op.ack_n   = ack_q;

endmodule

//--- tb.f
common/i2c_pkg.sv
common/i2c_op_if.sv
i2c_ctrl/i2c_ctrl.sv
rtl/i2c_bus_seq.sv
rtl/i2c_shift_reg.sv
rtl/i2c_master_top.sv
test/i2c_eeprom_model.sv
test/tb_i2c_master.sv

//--- test/i2c_eeprom_model.sv
//----------------------------------------------------------
// behavioral i2c EEPROM slave
// byte write and random read, 8-bit or 16-bit word address
//----------------------------------------------------------
`timescale 1ns/100ps

module i2c_eeprom_model #(
    parameter logic [6:0] dev_addr = 7'h50,
    parameter bit         addr16   = 1'b1
) (
    input  logic scl,
    inout  wire  sda
);

    typedef enum {ph_idle, ph_dev, ph_ahi, ph_alo, ph_data, ph_read} phase_e;

    phase_e      phase     = ph_idle;
    phase_e      phase_nxt = ph_idle;
    logic [7:0]  sr        = 8'h00;
    logic [7:0]  rd_byte   = 8'hff;
    logic [15:0] ptr       = 16'h0000;
    logic        pull      = 1'b0;               // model holds sda low
    int          bit_cnt   = 0;                  // scl rising edges in this frame
    logic [7:0]  mem [0:65535];

    assign sda = pull ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i[15:8] ^ i[7:0] ^ 8'h5a); // whole-address fill
    end

    // start and repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            phase   = ph_dev;
            bit_cnt = 0;
            pull    = 1'b0;
        end
    end

    // stop
    always @(posedge sda) begin
        if (scl === 1'b1)
            phase = ph_idle;
    end

    // received byte, decide ack and next phase
    task automatic accept_byte();
        logic ack;
        ack = 1'b1;
        case (phase)
            ph_dev: begin
                ack = (sr[7:1] == dev_addr);
                if (!ack)
                    phase_nxt = ph_idle;         // not addressed
                else if (sr[0])
                    phase_nxt = ph_read;
                else
                    phase_nxt = addr16 ? ph_ahi : ph_alo;
            end
            ph_ahi: begin
                ptr[15:8] = sr;
                phase_nxt = ph_alo;
            end
            ph_alo: begin
                ptr       = addr16 ? {ptr[15:8], sr} : {8'h00, sr};
                phase_nxt = ph_data;
            end
            default: begin
                mem[ptr]  = sr;
                ptr       = ptr + 1'b1;
                phase_nxt = ph_data;
            end
        endcase
        pull = ack;
    endtask

    always @(posedge scl) begin
        if (phase != ph_idle) begin
            if (bit_cnt < 8)
                sr = {sr[6:0], sda};
            else if (phase == ph_read && sda !== 1'b0)
                phase_nxt = ph_idle;             // master nack ends the read
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl) begin
        if (phase != ph_idle) begin
            if (bit_cnt == 8) begin
                if (phase == ph_read) begin
                    pull      = 1'b0;            // master acks this bit
                    phase_nxt = ph_read;
                end else begin
                    accept_byte();
                end
            end else if (bit_cnt == 9) begin
                pull    = 1'b0;
                bit_cnt = 0;
                phase   = phase_nxt;
                if (phase == ph_read) begin
                    rd_byte = mem[ptr];
                    ptr     = ptr + 1'b1;
                    pull    = !rd_byte[7];       // msb first
                end
            end else if (phase == ph_read && bit_cnt > 0) begin
                pull = !rd_byte[7 - bit_cnt];
            end
        end
    end

endmodule

//--- test/tb_i2c_master.sv
//----------------------------------------------------------
// testbench for the i2c EEPROM master
// random writes and reads against two EEPROM models
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_i2c_master import i2c_pkg::*; ();

    localparam int        stop_hold = 12;
    localparam int        n_rand    = 6;         // addresses per addressing mode
    localparam int        n_xfer    = 4 * n_rand + 7;
    localparam int        gap       = 10;        // idle cycles watched after done
    localparam int        xfer_max  = 5 * (start_cycles + 9 * bit_cycles) + bit_cycles + stop_hold;
    localparam int        wd_cycles = 16 + n_xfer * (xfer_max + gap + 4) + 200;
    localparam dev_addr_t dev16     = 7'h50;
    localparam dev_addr_t dev8      = 7'h51;
    localparam dev_addr_t dev_none  = 7'h2a;     // no model answers

    logic       dri_clk;
    logic       rst_n;
    logic       exec;
    logic       addr16;
    logic       rd;
    dev_addr_t  dev_addr;
    word_addr_t word_addr;
    byte_t      data_w;
    byte_t      data_r;
    logic       done;
    logic       nack;
    logic       scl;
    tri1        sda;                             // bus pull-up

    byte_t      ref16 [0:65535];                 // mirror of the 16-bit device
    byte_t      ref8  [0:255];
    word_addr_t addr_list [$];
    int         n_checks = 0;
    int         n_errors = 0;
    int         n_pass   = 0;
    int         n_fail   = 0;

    i2c_master_top #(.stop_hold(stop_hold)) dut_i (
        .dri_clk   (dri_clk),
        .rst_n     (rst_n),
        .exec      (exec),
        .addr16    (addr16),
        .rd        (rd),
        .dev_addr  (dev_addr),
        .word_addr (word_addr),
        .data_w    (data_w),
        .data_r    (data_r),
        .done      (done),
        .nack      (nack),
        .scl       (scl),
        .sda       (sda)
    );

    i2c_eeprom_model #(.dev_addr(dev16), .addr16(1'b1)) eeprom16_i (.scl(scl), .sda(sda));
    i2c_eeprom_model #(.dev_addr(dev8), .addr16(1'b0)) eeprom8_i (.scl(scl), .sda(sda));

    initial begin
        dri_clk = 1'b0;
        forever #10 dri_clk = ~dri_clk;
    end

    initial begin
        #(wd_cycles * 20);
        $display("watchdog: run did not finish within %0d cycles", wd_cycles);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            n_errors++;
        end
    endtask

    task automatic finish_test(input string name, input int base);
        if (n_errors == base) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: FAILED with %0d errors", name, n_errors - base);
        end
    endtask

    //----------------------------------------------------------
    // one request, wait for done, then watch the idle bus
    //----------------------------------------------------------
    task automatic run_xfer(input string name, input logic rd_i, input logic a16_i,
                            input dev_addr_t dev_i, input word_addr_t wa_i, input byte_t wd_i,
                            input bit poke, output byte_t rdata, output logic rnack);
        int   cyc;
        int   n_done;
        logic idle_ok;
        @(posedge dri_clk);
        #2;
        exec      = 1'b1;
        rd        = rd_i;
        addr16    = a16_i;
        dev_addr  = dev_i;
        word_addr = wa_i;
        data_w    = wd_i;
        cyc       = 0;
        n_done    = 0;
        while (n_done == 0) begin
            @(posedge dri_clk);
            #2;
            cyc++;
            exec      = poke && (cyc == 5 || cyc == 60); // busy, must be ignored
            rd        = 1'($urandom);
            addr16    = 1'($urandom);
            dev_addr  = dev_addr_t'($urandom);
            word_addr = word_addr_t'($urandom);
            data_w    = byte_t'($urandom);
            if (done) begin
                n_done = 1;
                rdata  = data_r;
                rnack  = nack;
            end
        end
        idle_ok = 1'b1;
        repeat (gap) begin
            @(posedge dri_clk);
            #2;
            if (done)
                n_done++;
            if (scl !== 1'b1 || sda !== 1'b1)
                idle_ok = 1'b0;
        end
        check_val({name, " done count"}, 16'd1, 16'(n_done));
        n_checks++;
        assert (idle_ok) else begin
            $display("%s: bus did not stay idle after done", name);
            n_errors++;
        end
    endtask

    // request plus expected result from the mirror memory
    task automatic access(input string name, input logic rd_i, input logic a16_i,
                          input dev_addr_t dev_i, input word_addr_t wa_i, input bit poke,
                          input logic exp_nack);
        byte_t wd;
        byte_t rdata;
        logic  rnack;
        byte_t exp;
        wd = byte_t'($urandom);
        run_xfer(name, rd_i, a16_i, dev_i, wa_i, wd, poke, rdata, rnack);
        check_val({name, " nack"}, 16'(exp_nack), 16'(rnack));
        if (!exp_nack) begin
            if (rd_i) begin
                exp = a16_i ? ref16[wa_i] : ref8[wa_i[7:0]];
                check_val({name, " data"}, 16'(exp), 16'(rdata));
            end else if (a16_i) begin
                ref16[wa_i] = wd;
            end else begin
                ref8[wa_i[7:0]] = wd;            // upper byte never sent
            end
        end
    endtask

    //----------------------------------------------------------
    // test sequence
    //----------------------------------------------------------
    initial begin
        word_addr_t wa;
        int         base;
        void'($urandom(32'hbdba13ac));
        rst_n     = 1'b0;
        exec      = 1'b0;
        addr16    = 1'b0;
        rd        = 1'b0;
        dev_addr  = '0;
        word_addr = '0;
        data_w    = '0;
        repeat (16) @(posedge dri_clk);
        #2;
        rst_n = 1'b1;
        repeat (3) @(posedge dri_clk);
        #2;

        base = n_errors;
        check_val("reset_idle scl", 16'd1, 16'(scl));
        check_val("reset_idle sda", 16'd1, 16'(sda));
        check_val("reset_idle done", 16'd0, 16'(done));
        check_val("reset_idle nack", 16'd0, 16'(nack));
        finish_test("reset_idle", base);

        base = n_errors;
        repeat (n_rand) begin
            wa = word_addr_t'($urandom);
            addr_list.push_back(wa);
            access($sformatf("wr_rd_16bit wr %h", wa), 1'b0, 1'b1, dev16, wa, 1'b0, 1'b0);
        end
        foreach (addr_list[i])
            access($sformatf("wr_rd_16bit rd %h", addr_list[i]), 1'b1, 1'b1, dev16,
                   addr_list[i], 1'b0, 1'b0);
        finish_test("wr_rd_16bit", base);

        base = n_errors;
        addr_list.delete();
        repeat (n_rand) begin
            wa = word_addr_t'($urandom);
            addr_list.push_back(wa);
            access($sformatf("wr_rd_8bit wr %h", wa), 1'b0, 1'b0, dev8, wa, 1'b0, 1'b0);
        end
        foreach (addr_list[i])
            access($sformatf("wr_rd_8bit rd %h", addr_list[i]), 1'b1, 1'b0, dev8,
                   addr_list[i], 1'b0, 1'b0);
        finish_test("wr_rd_8bit", base);

        base = n_errors;
        wa = word_addr_t'($urandom);
        access("nack_recovery wr", 1'b0, 1'b1, dev_none, wa, 1'b0, 1'b1);
        access("nack_recovery rd", 1'b1, 1'b0, dev_none, wa, 1'b0, 1'b1);
        access("nack_recovery good rd", 1'b1, 1'b0, dev8, addr_list[0], 1'b0, 1'b0);
        finish_test("nack_recovery", base);

        base = n_errors;
        addr_list.delete();
        repeat (2) begin
            wa = word_addr_t'($urandom);
            addr_list.push_back(wa);
            access($sformatf("busy_exec wr %h", wa), 1'b0, 1'b1, dev16, wa, 1'b1, 1'b0);
        end
        foreach (addr_list[i])
            access($sformatf("busy_exec rd %h", addr_list[i]), 1'b1, 1'b1, dev16,
                   addr_list[i], 1'b1, 1'b0);
        finish_test("busy_exec", base);

        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 n_pass, n_fail, n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
